//--- list.f
hdl/lsu_pkg.sv
hdl/mem_decode.sv
hdl/mem_execute.sv
hdl/data_mem.sv
hdl/mem_result.sv
hdl/lsu_top.sv
dv/lsu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the lsu testbench with verilator, run it, and check the log for the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG" build.log

verilator --binary --timing --assert -j 0 \
    --top-module lsu_tb -o lsu_sim -f list.f > build.log 2>&1 \
    || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/lsu_sim > "$LOG" 2>&1 \
    || echo "simulator returned a nonzero status"
cat "$LOG"

grep -qx "TESTBENCH PASSED" "$LOG" \
    && { echo "result: pass"; exit 0; } \
    || { echo "result: fail"; exit 1; }

//--- dv/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;

    localparam int NUM_WORD    = 16;                // sw/lw pairs
    localparam int NUM_BYTE    = 16;                // sw, sb, lb, lbu, lw groups
    localparam int NUM_MIS     = 6;                 // misaligned groups
    localparam int NUM_TXN     = NUM_WORD*2 + NUM_BYTE*5 + NUM_MIS*5 + 10;
    localparam int CYCLE_LIMIT = NUM_TXN*12 + 64;  // at most 9 used per transaction

    logic            clk;
    logic            rst;
    logic            req;
    logic [31:0]     instr;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic            ack;
    logic [4:0]      rd_addr;
    logic [XLEN-1:0] rd_data;
    logic            rd_we;
    logic            fault_misalign;
    logic            fault_illegal;

    // expected response of the transaction in flight
    logic            exp_we;
    logic            exp_mis;
    logic            exp_ill;
    logic            exp_chk;  // rd_addr and rd_data compared
    logic [4:0]      exp_rd;
    logic [XLEN-1:0] exp_data;

    logic [7:0]      shadow [2**MEM_ADDR_WIDTH];  // bytes written by this testbench
    logic [31:0]     rng_state;
    int              value_errs    = 0;
    int              protocol_errs = 0;
    int              cycle_count   = 0;

    lsu_top lsu_top_inst (
        .clk            (clk),
        .rst            (rst),
        .req            (req),
        .instr          (instr),
        .rs1_val        (rs1_val),
        .rs2_val        (rs2_val),
        .ack            (ack),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .rd_we          (rd_we),
        .fault_misalign (fault_misalign),
        .fault_illegal  (fault_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, a handshake never completed", cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // outputs quiet once reset is released
    reset_chk: assert property (@(posedge clk) $fell(rst) |-> !ack && !rd_we && !fault_misalign
        && !fault_illegal && !lsu_top_inst.dec_valid && !lsu_top_inst.ex_valid
        && !lsu_top_inst.mem_wr)
        else begin
            protocol_errs++;
            $display("%0t: outputs or stage valids not low after reset", $time);
        end

    dec_pulse_chk: assert property (@(posedge clk) disable iff (rst)
        $rose(req) |=> lsu_top_inst.dec_valid ##1 !lsu_top_inst.dec_valid)
        else begin
            protocol_errs++;
            $display("%0t: decode did not pulse dec_valid for one cycle after req", $time);
        end

    ack_rise_chk: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req, 3) && !$past(req, 4))  // exactly 3 edges after req sampled
        else begin
            protocol_errs++;
            $display("%0t: ack did not rise three edges after req was sampled high", $time);
        end

    ack_fall_chk: assert property (@(posedge clk) disable iff (rst) ack && !req |=> !ack)
        else begin
            protocol_errs++;
            $display("%0t: ack stayed high after req was sampled low", $time);
        end

    ack_hold_chk: assert property (@(posedge clk) disable iff (rst) ack && req |=> ack)
        else begin
            protocol_errs++;
            $display("%0t: ack dropped while req was still high", $time);
        end

    hold_chk: assert property (@(posedge clk) disable iff (rst) ack && $past(ack) |->
        $stable(rd_data) && $stable(rd_addr) && $stable(rd_we)
        && $stable(fault_misalign) && $stable(fault_illegal))
        else begin
            protocol_errs++;
            $display("%0t: result outputs changed while ack was high", $time);
        end

    // response values against the expected fields
    we_chk: assert property (@(posedge clk) disable iff (rst) ack |-> rd_we == exp_we)
        else begin
            value_errs++;
            $display("ERR %0t rd_we expected %0b got %0b", $time, exp_we, $sampled(rd_we));
        end

    mis_chk: assert property (@(posedge clk) disable iff (rst) ack |-> fault_misalign == exp_mis)
        else begin
            value_errs++;
            $display("ERR %0t fault_misalign expected %0b got %0b", $time, exp_mis,
                     $sampled(fault_misalign));
        end

    ill_chk: assert property (@(posedge clk) disable iff (rst) ack |-> fault_illegal == exp_ill)
        else begin
            value_errs++;
            $display("ERR %0t fault_illegal expected %0b got %0b", $time, exp_ill,
                     $sampled(fault_illegal));
        end

    rd_chk: assert property (@(posedge clk) disable iff (rst) ack && exp_chk |-> rd_addr == exp_rd)
        else begin
            value_errs++;
            $display("ERR %0t rd_addr expected %0d got %0d", $time, exp_rd, $sampled(rd_addr));
        end

    data_chk: assert property (@(posedge clk) disable iff (rst)
        ack && exp_chk |-> rd_data == exp_data)
        else begin
            value_errs++;
            $display("ERR %0t rd_data expected %08h got %08h", $time, exp_data,
                     $sampled(rd_data));
        end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [4:0] pick_rd();
        logic [31:0] r;
        r = next_rand();
        return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];  // never x0
    endfunction

    function automatic logic [31:0] make_load_instr(input logic [2:0] f3, input logic [4:0] rd,
                                                    input logic [11:0] imm);
        return {imm, 5'd10, f3, rd, OPC_LOAD};  // i-type
    endfunction

    function automatic logic [31:0] make_store_instr(input logic [2:0] f3, input logic [11:0] imm);
        return {imm[11:5], 5'd11, 5'd10, f3, imm[4:0], OPC_STORE};  // s-type
    endfunction

    // base register so that base + sext(imm) lands on addr, random upper bits
    function automatic logic [31:0] rs1_for_addr(input logic [MEM_ADDR_WIDTH-1:0] addr,
                                                 input logic [11:0] imm, input logic [31:0] up);
        logic [31:0] target;
        target = {up[31:MEM_ADDR_WIDTH], addr};
        return target - {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] shadow_word(input logic [MEM_ADDR_WIDTH-1:0] addr);
        logic [MEM_ADDR_WIDTH-3:0] w;
        w = addr[MEM_ADDR_WIDTH-1:2];
        return {shadow[{w, 2'd3}], shadow[{w, 2'd2}], shadow[{w, 2'd1}], shadow[{w, 2'd0}]};
    endfunction

    task automatic set_expected(input logic we, input logic mis, input logic ill,
                                input logic chk, input logic [4:0] rd, input logic [31:0] data);
        exp_we   = we;
        exp_mis  = mis;
        exp_ill  = ill;
        exp_chk  = chk;
        exp_rd   = rd;
        exp_data = data;
    endtask

    // one four-phase transaction, entered right after a rising edge
    task automatic handshake(input logic [31:0] i, input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        r       = next_rand();
        req     <= 1'b1;
        instr   <= i;
        rs1_val <= a;
        rs2_val <= b;
        @(posedge clk);
        while (!ack) @(posedge clk);
        repeat (r[1:0]) @(posedge clk);  // requester back-pressure, 0 to 3 extra cycles
        req <= 1'b0;
        @(posedge clk);
        while (ack) @(posedge clk);  // back to idle
    endtask

    task automatic store(input logic [2:0] f3, input logic [MEM_ADDR_WIDTH-1:0] addr,
                         input logic [31:0] data);
        logic [31:0]               r;
        logic [11:0]               imm;
        logic [31:0]               rs1;
        logic                      mis;
        logic [MEM_ADDR_WIDTH-3:0] w;
        r   = next_rand();
        imm = r[11:0];
        rs1 = rs1_for_addr(addr, imm, next_rand());
        mis = (f3 == F3_SW) && (addr[1:0] != 2'b00);
        w   = addr[MEM_ADDR_WIDTH-1:2];
        if (f3 == F3_SB) begin
            shadow[addr] = data[7:0];
        end else if (!mis) begin
            shadow[{w, 2'd0}] = data[7:0];  // little endian
            shadow[{w, 2'd1}] = data[15:8];
            shadow[{w, 2'd2}] = data[23:16];
            shadow[{w, 2'd3}] = data[31:24];
        end
        set_expected(1'b0, mis, 1'b0, 1'b0, 5'd0, 32'd0);
        handshake(make_store_instr(f3, imm), rs1, data);
    endtask

    task automatic load(input logic [2:0] f3, input logic [4:0] rd,
                        input logic [MEM_ADDR_WIDTH-1:0] addr);
        logic [31:0] r;
        logic [11:0] imm;
        logic [31:0] rs1;
        logic [31:0] data;
        logic        mis;
        logic [7:0]  b;
        r   = next_rand();
        imm = r[11:0];
        rs1 = rs1_for_addr(addr, imm, next_rand());
        mis = (f3 == F3_LW) && (addr[1:0] != 2'b00);
        b   = shadow[addr];
        case (f3)
            F3_LB:   data = {{24{b[7]}}, b};
            F3_LBU:  data = {24'd0, b};
            default: data = shadow_word(addr);
        endcase
        set_expected(!mis && (rd != 5'd0), mis, 1'b0, !mis, rd, data);
        handshake(make_load_instr(f3, rd, imm), rs1, next_rand());
    endtask

    task automatic illegal(input logic [31:0] i);
        set_expected(1'b0, 1'b0, 1'b1, 1'b0, 5'd0, 32'd0);
        handshake(i, next_rand(), next_rand());
    endtask

    initial begin
        logic [31:0]               r;
        logic [31:0]               d;
        logic [MEM_ADDR_WIDTH-1:0] base;
        logic [MEM_ADDR_WIDTH-1:0] a;
        rst       = 1'b1;
        req       = 1'b0;
        instr     = 32'd0;
        rs1_val   = '0;
        rs2_val   = '0;
        rng_state = 32'd25793;
        set_expected(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        for (int i = 0; i < NUM_WORD; i++) begin  // word round trips
            r    = next_rand();
            base = {r[MEM_ADDR_WIDTH-1:2], 2'b00};
            store(F3_SW, base, next_rand());
            load(F3_LW, pick_rd(), base);
        end

        for (int i = 0; i < NUM_BYTE; i++) begin  // byte lanes inside a known word
            r    = next_rand();
            base = {r[MEM_ADDR_WIDTH-1:2], 2'b00};
            store(F3_SW, base, next_rand());
            r    = next_rand();
            a    = {base[MEM_ADDR_WIDTH-1:2], r[1:0]};
            d    = next_rand();
            d[7] = i[0];  // both signs of byte
            store(F3_SB, a, d);
            load(F3_LB, pick_rd(), a);
            load(F3_LBU, pick_rd(), a);
            load(F3_LW, pick_rd(), base);
        end

        for (int i = 0; i < NUM_MIS; i++) begin
            r    = next_rand();
            base = {r[MEM_ADDR_WIDTH-1:2], 2'b00};
            store(F3_SW, base, next_rand());
            r    = next_rand();
            a    = {base[MEM_ADDR_WIDTH-1:2], (r[1:0] == 2'b00) ? 2'b01 : r[1:0]};
            store(F3_SW, a, next_rand());  // faults, no write
            load(F3_LW, pick_rd(), a);
            load(F3_LB, pick_rd(), a);     // byte access at same address is fine
            load(F3_LW, pick_rd(), base);  // word still intact
        end

        illegal({7'd0, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011});  // r-type add
        illegal(make_load_instr(3'b001, 5'd4, 12'h010));        // lh
        illegal(make_load_instr(3'b101, 5'd5, 12'hff0));        // lhu
        illegal(make_load_instr(3'b011, 5'd6, 12'h004));        // ld, not rv32
        illegal(make_store_instr(3'b001, 12'h008));             // sh
        load(F3_LW, 5'd0, base);  // x0 target, no writeback
        load(F3_LB, 5'd0, base);

        repeat (4) @(posedge clk);
        $display("value errors: %0d, protocol errors: %0d", value_errs, protocol_errs);
        if (value_errs == 0 && protocol_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- hdl/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,
    input  logic [31:0]              instr,
    input  logic [lsu_pkg::XLEN-1:0] rs1_val,
    input  logic [lsu_pkg::XLEN-1:0] rs2_val,
    output logic                     ack,
    output logic [4:0]               rd_addr,
    output logic [lsu_pkg::XLEN-1:0] rd_data,
    output logic                     rd_we,
    output logic                     fault_misalign,
    output logic                     fault_illegal
);
    import lsu_pkg::*;

    // decode -> execute
    logic                      dec_valid;
    mem_op_t                   dec_op;
    logic [XLEN-1:0]           dec_imm;
    logic [4:0]                dec_rd;
    logic [XLEN-1:0]           dec_rs1;
    logic [XLEN-1:0]           dec_rs2;

    // execute -> memory
    mem_op_t                   mem_op;
    logic [MEM_ADDR_WIDTH-1:0] mem_addr;
    logic [XLEN-1:0]           mem_wdata;
    logic                      mem_wr;
    logic [XLEN-1:0]           mem_rdata;

    // execute -> result
    logic                      ex_valid;
    mem_op_t                   ex_op;
    logic [4:0]                ex_rd;
    logic                      ex_misalign;

    mem_decode mem_decode_inst (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .instr     (instr),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .ack       (ack),        // re-arm on return to idle
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .dec_imm   (dec_imm),
        .dec_rd    (dec_rd),
        .dec_rs1   (dec_rs1),
        .dec_rs2   (dec_rs2)
    );

    mem_execute mem_execute_inst (
        .clk         (clk),
        .rst         (rst),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op),
        .dec_imm     (dec_imm),
        .dec_rd      (dec_rd),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_rd       (ex_rd),
        .ex_misalign (ex_misalign),
        .mem_op      (mem_op),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wr      (mem_wr)
    );

    data_mem data_mem_inst (
        .clk       (clk),
        .mem_op    (mem_op),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wr    (mem_wr),
        .mem_rdata (mem_rdata)  // combinational, same cycle as ex_valid
    );

    mem_result mem_result_inst (
        .clk            (clk),
        .rst            (rst),
        .req            (req),
        .ex_valid       (ex_valid),
        .ex_op          (ex_op),
        .ex_rd          (ex_rd),
        .ex_misalign    (ex_misalign),
        .mem_rdata      (mem_rdata),
        .ack            (ack),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .rd_we          (rd_we),
        .fault_misalign (fault_misalign),
        .fault_illegal  (fault_illegal)
    );

endmodule

//--- hdl/mem_result.sv
`timescale 1ns/1ps

module mem_result (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,           // watched to drop ack
    input  logic                     ex_valid,
    input  lsu_pkg::mem_op_t         ex_op,
    input  logic [4:0]               ex_rd,
    input  logic                     ex_misalign,
    input  logic [lsu_pkg::XLEN-1:0] mem_rdata,
    output logic                     ack,
    output logic [4:0]               rd_addr,
    output logic [lsu_pkg::XLEN-1:0] rd_data,
    output logic                     rd_we,
    output logic                     fault_misalign,
    output logic                     fault_illegal
);
    import lsu_pkg::*;

    logic [BYTE_WIDTH-1:0] rd_byte;
    logic [XLEN-1:0]       load_data;
    logic                  is_load;
    logic                  illegal;

    assign rd_byte = mem_rdata[BYTE_WIDTH-1:0];
    assign illegal = (ex_op == OP_ILLEGAL);
    assign is_load = (ex_op == OP_LW) || (ex_op == OP_LB) || (ex_op == OP_LBU);

    always_comb begin
        case (ex_op)
            OP_LW:   load_data = mem_rdata;
            OP_LB:   load_data = {{(XLEN-BYTE_WIDTH){rd_byte[BYTE_WIDTH-1]}}, rd_byte};
            OP_LBU:  load_data = {{(XLEN-BYTE_WIDTH){1'b0}}, rd_byte};
            default: load_data = '0;  // stores and illegal return zero
        endcase
    end

    // ack and flags
    always_ff @(posedge clk) begin
        if (rst) begin
            ack            <= 1'b0;
            rd_we          <= 1'b0;
            fault_misalign <= 1'b0;
            fault_illegal  <= 1'b0;
        end else if (ex_valid) begin
            ack            <= 1'b1;  // results valid from here
            rd_we          <= is_load && !ex_misalign && !illegal && (ex_rd != 5'd0);
            fault_misalign <= ex_misalign;
            fault_illegal  <= illegal;
        end else if (ack && !req) begin
            ack            <= 1'b0;  // requester let go
            rd_we          <= 1'b0;
            fault_misalign <= 1'b0;
            fault_illegal  <= 1'b0;
        end
    end

    // writeback payload, held until next transaction
    always_ff @(posedge clk) begin
        if (ex_valid) begin
            rd_addr <= ex_rd;
            rd_data <= load_data;
        end
    end

endmodule

//--- hdl/data_mem.sv
`timescale 1ns/1ps

module data_mem (
    input  logic                               clk,
    input  lsu_pkg::mem_op_t                   mem_op,
    input  logic [lsu_pkg::MEM_ADDR_WIDTH-1:0] mem_addr,   // byte address
    input  logic [lsu_pkg::XLEN-1:0]           mem_wdata,
    input  logic                               mem_wr,     // write strobe from execute
    output logic [lsu_pkg::XLEN-1:0]           mem_rdata
);
    import lsu_pkg::*;

    localparam int DEPTH = 2**MEM_ADDR_WIDTH;

    logic [BYTE_WIDTH-1:0]     mem_array [DEPTH];  // no init, contents undefined
    logic [MEM_ADDR_WIDTH-1:0] addr_b0;            // word base, lowest byte
    logic [MEM_ADDR_WIDTH-1:0] addr_b1;
    logic [MEM_ADDR_WIDTH-1:0] addr_b2;
    logic [MEM_ADDR_WIDTH-1:0] addr_b3;            // word base, highest byte

    // byte lanes of the aligned word, little endian
    assign addr_b0 = {mem_addr[MEM_ADDR_WIDTH-1:2], 2'd0};
    assign addr_b1 = {mem_addr[MEM_ADDR_WIDTH-1:2], 2'd1};
    assign addr_b2 = {mem_addr[MEM_ADDR_WIDTH-1:2], 2'd2};
    assign addr_b3 = {mem_addr[MEM_ADDR_WIDTH-1:2], 2'd3};

    // synchronous write
    always_ff @(posedge clk) begin
        if (mem_wr) begin
            case (mem_op)
                OP_SW: begin
                    mem_array[addr_b0] <= mem_wdata[7:0];
                    mem_array[addr_b1] <= mem_wdata[15:8];
                    mem_array[addr_b2] <= mem_wdata[23:16];
                    mem_array[addr_b3] <= mem_wdata[31:24];
                end
                OP_SB: begin
                    mem_array[mem_addr] <= mem_wdata[BYTE_WIDTH-1:0];  // low byte only
                end
                default: begin
                end
            endcase
        end
    end

    // asynchronous read, raw byte for byte ops
    always_comb begin
        mem_rdata = '0;
        case (mem_op)
            OP_LW, OP_SW: begin
                mem_rdata = {mem_array[addr_b3], mem_array[addr_b2],
                             mem_array[addr_b1], mem_array[addr_b0]};
            end
            OP_LB, OP_LBU, OP_SB: begin
                mem_rdata[BYTE_WIDTH-1:0] = mem_array[mem_addr];  // extension in result
            end
            default: begin
                mem_rdata = '0;  // nothing driven for illegal ops
            end
        endcase
    end

endmodule

//--- hdl/mem_execute.sv
`timescale 1ns/1ps

module mem_execute (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               dec_valid,
    input  lsu_pkg::mem_op_t                   dec_op,
    input  logic [lsu_pkg::XLEN-1:0]           dec_imm,
    input  logic [4:0]                         dec_rd,
    input  logic [lsu_pkg::XLEN-1:0]           dec_rs1,
    input  logic [lsu_pkg::XLEN-1:0]           dec_rs2,
    output logic                               ex_valid,
    output lsu_pkg::mem_op_t                   ex_op,
    output logic [4:0]                         ex_rd,
    output logic                               ex_misalign,
    output lsu_pkg::mem_op_t                   mem_op,
    output logic [lsu_pkg::MEM_ADDR_WIDTH-1:0] mem_addr,
    output logic [lsu_pkg::XLEN-1:0]           mem_wdata,
    output logic                               mem_wr
);
    import lsu_pkg::*;

    logic [XLEN-1:0] eff_addr;
    logic            is_word;
    logic            is_store;
    logic            misalign;
    mem_op_t         op_q;

    assign eff_addr = dec_rs1 + dec_imm;  // base + offset, wraps at 32 bits
    assign is_word  = (dec_op == OP_LW) || (dec_op == OP_SW);
    assign is_store = (dec_op == OP_SW) || (dec_op == OP_SB);
    assign misalign = is_word && (eff_addr[1:0] != 2'b00);  // bytes never misalign

    // control registers
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
            mem_wr   <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
            mem_wr   <= dec_valid && is_store && !misalign;  // one-cycle write strobe
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            op_q        <= dec_op;
            ex_rd       <= dec_rd;
            ex_misalign <= misalign;
            mem_addr    <= eff_addr[MEM_ADDR_WIDTH-1:0];  // upper bits dropped
            mem_wdata   <= dec_rs2;
        end
    end

    // same registered op feeds memory and result stage
    assign ex_op  = op_q;
    assign mem_op = op_q;

endmodule

//--- hdl/mem_decode.sv
`timescale 1ns/1ps

module mem_decode (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,      // four-phase request
    input  logic [31:0]              instr,
    input  logic [lsu_pkg::XLEN-1:0] rs1_val,
    input  logic [lsu_pkg::XLEN-1:0] rs2_val,
    input  logic                     ack,      // from result stage, used to re-arm
    output logic                     dec_valid,
    output lsu_pkg::mem_op_t         dec_op,
    output logic [lsu_pkg::XLEN-1:0] dec_imm,
    output logic [4:0]               dec_rd,
    output logic [lsu_pkg::XLEN-1:0] dec_rs1,
    output logic [lsu_pkg::XLEN-1:0] dec_rs2
);
    import lsu_pkg::*;

    typedef enum logic {S_IDLE, S_BUSY} state_t;

    state_t           state;
    logic             capture;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    mem_op_t          op_next;
    logic [XLEN-1:0]  imm_i;
    logic [XLEN-1:0]  imm_s;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign capture = (state == S_IDLE) && req && !ack;  // only one transaction in flight

    // sign-extended immediates
    assign imm_i = {{(XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};

    always_comb begin
        op_next = OP_ILLEGAL;  // default for unknown opcode/funct3
        if (opcode == OPC_LOAD) begin
            case (funct3)
                F3_LW:   op_next = OP_LW;
                F3_LB:   op_next = OP_LB;
                F3_LBU:  op_next = OP_LBU;
                default: op_next = OP_ILLEGAL;  // lh, lhu, reserved
            endcase
        end else if (opcode == OPC_STORE) begin
            case (funct3)
                F3_SW:   op_next = OP_SW;
                F3_SB:   op_next = OP_SB;
                default: op_next = OP_ILLEGAL;  // sh, reserved
            endcase
        end
    end

    // idle/busy control
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= capture;  // single-cycle pulse
            if (capture) begin
                state <= S_BUSY;
            end else if (state == S_BUSY && !req && !ack) begin
                state <= S_IDLE;  // handshake back to idle
            end
        end
    end

    // decoded payload, loaded on capture only
    always_ff @(posedge clk) begin
        if (capture) begin
            dec_op  <= op_next;
            dec_imm <= (opcode == OPC_STORE) ? imm_s : imm_i;
            dec_rd  <= (opcode == OPC_LOAD) ? instr[11:7] : 5'd0;  // stores have no rd
            dec_rs1 <= rs1_val;
            dec_rs2 <= rs2_val;
        end
    end

endmodule

//--- hdl/lsu_pkg.sv
package lsu_pkg;

    // datapath widths
    localparam int XLEN           = 32;
    localparam int MEM_ADDR_WIDTH = 10;  // 1 KiB of byte locations
    localparam int BYTE_WIDTH     = 8;   // one memory location

    // rv32i major opcodes, instr[6:0]
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // funct3 for loads, instr[14:12]
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;

    // funct3 for stores
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SW = 3'b010;

    // operation carried down the pipe
    // halfword forms are not supported and decode as illegal
    typedef enum logic [2:0] {
        OP_LW      = 3'd0,  // load word
        OP_LB      = 3'd1,  // load byte, sign extended
        OP_LBU     = 3'd2,  // load byte, zero extended
        OP_SW      = 3'd3,  // store word
        OP_SB      = 3'd4,  // store byte
        OP_ILLEGAL = 3'd7   // anything else
    } mem_op_t;

endpackage
